// ==== logic/cpuPkg.sv ====
// ################################################
// Shared ISA definitions for the proc core: widths,
// opcode, ALU operation and forwarding select encodings
// ################################################
package cpuPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int dmemDepth    = 256;

   // Instruction bits 15..12, codes 11 to 15 are illegal
   typedef enum logic [3:0] {
      opAdd  = 4'd0,
      opSub  = 4'd1,
      opAnd  = 4'd2,
      opXor  = 4'd3,
      opAddi = 4'd4,
      opLd   = 4'd5,
      opSt   = 4'd6,
      opBeqz = 4'd7,
      opJ    = 4'd8,
      opHalt = 4'd9,
      opNop  = 4'd10
   } opcodeT;

   typedef enum logic [1:0] {
      aluAdd = 2'd0,
      aluSub = 2'd1,
      aluAnd = 2'd2,
      aluXor = 2'd3
   } aluOpT;

   // Where an execute operand comes from
   typedef enum logic [1:0] {
      fwdReg = 2'd0,
      fwdMem = 2'd1,
      fwdWb  = 2'd2
   } fwdSelT;

endpackage

// ==== logic/fetch.sv ====
// ################################################
// Program counter for the fetch stage, drives the
// instruction ROM address
// ################################################
`timescale 1ns/1ps

module fetch (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          stall,
   input  logic                          redirect,
   input  logic [cpuPkg::dataWidth-1:0]  redirectPc,
   input  logic                          halted,
   output logic [cpuPkg::dataWidth-1:0]  pc
);

   // Halt freezes the PC even against a late redirect
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (halted) begin
         pc <= pc;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall) begin
         pc <= pc + 1'b1;
      end
   end

   // A load in ID/EX cannot also be a branch or jump
   assert property (@(posedge clk) disable iff (!rstN) !(redirect && stall));

endmodule

// ==== logic/regFile.sv ====
// ################################################
// Eight-entry register file read in decode, written
// in writeback with same-cycle bypass to the reads
// ################################################
`timescale 1ns/1ps

module regFile (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
   input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
   input  logic                            wrEn,
   input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
   input  logic [cpuPkg::dataWidth-1:0]    wrData,
   output logic [cpuPkg::dataWidth-1:0]    rdDataA,
   output logic [cpuPkg::dataWidth-1:0]    rdDataB
);
   import cpuPkg::*;

   logic [dataWidth-1:0] regs [1 << regAddrWidth];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < (1 << regAddrWidth); i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrAddr != '0) begin
         regs[wrAddr] <= wrData;
      end
   end

   // r0 is hardwired to zero
   assign rdDataA = (rdAddrA == '0) ? '0 :
                    (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (rdAddrB == '0) ? '0 :
                    (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== logic/decode.sv ====
// ################################################
// Decode stage: field split, control decode, immediate
// sign extension and register file read
// ################################################
`timescale 1ns/1ps

module decode (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [cpuPkg::dataWidth-1:0]    instr,
   input  logic                            wbEn,
   input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
   input  logic [cpuPkg::dataWidth-1:0]    wbData,
   output logic [cpuPkg::regAddrWidth-1:0] rs,
   output logic [cpuPkg::regAddrWidth-1:0] rt,
   output logic [cpuPkg::regAddrWidth-1:0] rd,
   output logic [cpuPkg::dataWidth-1:0]    opValA,
   output logic [cpuPkg::dataWidth-1:0]    opValB,
   output logic [cpuPkg::dataWidth-1:0]    imm,
   output cpuPkg::aluOpT                   aluOp,
   output logic                            useImm,
   output logic                            regWrite,
   output logic                            memRead,
   output logic                            memWrite,
   output logic                            isBranch,
   output logic                            isJump,
   output logic                            isHalt,
   output logic                            illegal
);
   import cpuPkg::*;

   opcodeT op;

   assign op = opcodeT'(instr[15:12]);
   assign rd = instr[11:9];
   assign rs = instr[8:6];
   // Store data comes from rd, read on port B
   assign rt = (op == opSt) ? instr[11:9] : instr[5:3];

   always_comb begin
      aluOp    = aluAdd;
      useImm   = 1'b0;
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      isJump   = 1'b0;
      isHalt   = 1'b0;
      illegal  = 1'b0;
      imm      = {{(dataWidth - 6){instr[5]}}, instr[5:0]};
      case (op)
         opAdd:  regWrite = 1'b1;
         opSub: begin
            aluOp    = aluSub;
            regWrite = 1'b1;
         end
         opAnd: begin
            aluOp    = aluAnd;
            regWrite = 1'b1;
         end
         opXor: begin
            aluOp    = aluXor;
            regWrite = 1'b1;
         end
         opAddi: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         opLd: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         opSt: begin
            useImm   = 1'b1;
            memWrite = 1'b1;
         end
         opBeqz: isBranch = 1'b1;
         opJ: begin
            isJump = 1'b1;
            imm    = {{(dataWidth - 12){instr[11]}}, instr[11:0]};
         end
         opHalt: isHalt = 1'b1;
         opNop:  ;
         // Unknown code leaves every enable low
         default: illegal = 1'b1;
      endcase
   end

   regFile i_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rs),
      .rdAddrB (rt),
      .wrEn    (wbEn),
      .wrAddr  (wbReg),
      .wrData  (wbData),
      .rdDataA (opValA),
      .rdDataB (opValB)
   );

endmodule

// ==== logic/hazardUnit.sv ====
// ################################################
// Forwarding selects for the execute operands and the
// one-cycle load-use stall
// ################################################
`timescale 1ns/1ps

module hazardUnit (
   // Sources of the instruction in decode
   input  logic [cpuPkg::regAddrWidth-1:0] idRs,
   input  logic [cpuPkg::regAddrWidth-1:0] idRt,
   // Load sitting in ID/EX
   input  logic                            idMemRead,
   input  logic [cpuPkg::regAddrWidth-1:0] idRd,
   input  logic [cpuPkg::regAddrWidth-1:0] exRs,
   input  logic [cpuPkg::regAddrWidth-1:0] exRt,
   input  logic [cpuPkg::regAddrWidth-1:0] memRd,
   input  logic                            memRegWrite,
   input  logic [cpuPkg::regAddrWidth-1:0] wbRd,
   input  logic                            wbRegWrite,
   output cpuPkg::fwdSelT                  fwdA,
   output cpuPkg::fwdSelT                  fwdB,
   output logic                            loadStall
);
   import cpuPkg::*;

   // Youngest writer wins and r0 never forwards
   function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
      if (memRegWrite && memRd != '0 && memRd == src) begin
         return fwdMem;
      end else if (wbRegWrite && wbRd != '0 && wbRd == src) begin
         return fwdWb;
      end
      return fwdReg;
   endfunction

   always_comb begin
      fwdA = pickSource(exRs);
      fwdB = pickSource(exRt);
   end

   assign loadStall = idMemRead && idRd != '0 && (idRd == idRs || idRd == idRt);

endmodule

// ==== logic/execute.sv ====
// ################################################
// Execute stage: forwarded operand select, ALU and
// branch or jump resolution
// ################################################
`timescale 1ns/1ps

module execute (
   input  cpuPkg::fwdSelT                fwdA,
   input  cpuPkg::fwdSelT                fwdB,
   input  logic [cpuPkg::dataWidth-1:0]  opValA,
   input  logic [cpuPkg::dataWidth-1:0]  opValB,
   input  logic [cpuPkg::dataWidth-1:0]  memResult,
   input  logic [cpuPkg::dataWidth-1:0]  wbResult,
   input  logic [cpuPkg::dataWidth-1:0]  imm,
   input  cpuPkg::aluOpT                 aluOp,
   input  logic                          useImm,
   input  logic                          isBranch,
   input  logic                          isJump,
   input  logic [cpuPkg::dataWidth-1:0]  pcPlusOne,
   output logic [cpuPkg::dataWidth-1:0]  aluResult,
   output logic [cpuPkg::dataWidth-1:0]  storeData,
   output logic                          redirect,
   output logic [cpuPkg::dataWidth-1:0]  redirectPc
);
   import cpuPkg::*;

   logic [dataWidth-1:0] valA;
   logic [dataWidth-1:0] valB;
   logic [dataWidth-1:0] aluB;

   assign valA = (fwdA == fwdMem) ? memResult : (fwdA == fwdWb) ? wbResult : opValA;
   assign valB = (fwdB == fwdMem) ? memResult : (fwdB == fwdWb) ? wbResult : opValB;
   assign aluB = useImm ? imm : valB;

   // Also forms the LD/ST address
   always_comb begin
      case (aluOp)
         aluSub:  aluResult = valA - aluB;
         aluAnd:  aluResult = valA & aluB;
         aluXor:  aluResult = valA ^ aluB;
         default: aluResult = valA + aluB;
      endcase
   end

   assign storeData  = valB;
   assign redirect   = isJump || (isBranch && valA == '0);
   assign redirectPc = pcPlusOne + imm;

endmodule

// ==== logic/dataMemory.sv ====
// ################################################
// Private data store for the memory stage, written on
// the clock edge and read combinationally
// ################################################
`timescale 1ns/1ps

module dataMemory (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [cpuPkg::dataWidth-1:0]  addr,
   input  logic [cpuPkg::dataWidth-1:0]  wrData,
   input  logic                          memRead,
   input  logic                          memWrite,
   output logic [cpuPkg::dataWidth-1:0]  rdData,
   output logic                          rangeErr
);
   import cpuPkg::*;

   logic [dataWidth-1:0] mem [dmemDepth];
   logic                 inRange;

   assign inRange  = addr < dmemDepth;
   assign rangeErr = (memRead || memWrite) && !inRange;

   always_ff @(posedge clk) begin
      if (rstN && memWrite && inRange) begin
         mem[addr[$clog2(dmemDepth)-1:0]] <= wrData;
      end
   end

   assign rdData = inRange ? mem[addr[$clog2(dmemDepth)-1:0]] : '0;

endmodule

// ==== logic/proc.sv ====
// ################################################
// Five-stage 16-bit core. Instruction ROM sits outside,
// writebacks leave as a trace, halted/err report status
// ################################################
`timescale 1ns/1ps

module proc (
   input  logic                            clk,
   input  logic                            rstN,
   output logic [cpuPkg::dataWidth-1:0]    instrAddr,
   input  logic [cpuPkg::dataWidth-1:0]    instr,
   output logic                            wbEn,
   output logic [cpuPkg::regAddrWidth-1:0] wbReg,
   output logic [cpuPkg::dataWidth-1:0]    wbData,
   output logic                            halted,
   output logic                            err
);
   import cpuPkg::*;

   logic                    stall, redirect, haltNow, kill, fault;
   logic [dataWidth-1:0]    pc, redirectPc;
   logic                    ifIdValid;
   logic [dataWidth-1:0]    ifIdInstr, ifIdPcPlusOne;

   logic [regAddrWidth-1:0] dRs, dRt, dRd;
   logic [dataWidth-1:0]    dOpA, dOpB, dImm;
   aluOpT                   dAluOp;
   logic                    dUseImm, dRegWrite, dMemRead, dMemWrite;
   logic                    dIsBranch, dIsJump, dIsHalt, dIllegal;

   logic                    idExValid;
   logic [regAddrWidth-1:0] idExRs, idExRt, idExRd;
   logic [dataWidth-1:0]    idExOpA, idExOpB, idExImm, idExPcPlusOne;
   aluOpT                   idExAluOp;
   logic                    idExUseImm, idExRegWrite, idExMemRead, idExMemWrite;
   logic                    idExIsBranch, idExIsJump, idExIsHalt, idExIllegal;

   fwdSelT                  fwdA, fwdB;
   logic [dataWidth-1:0]    aluResult, storeData;
   logic                    exMemValid, exMemRegWrite, exMemMemRead, exMemMemWrite;
   logic                    exMemIsHalt, exMemIllegal;
   logic [regAddrWidth-1:0] exMemRd;
   logic [dataWidth-1:0]    exMemAluResult, exMemStoreData;

   logic [dataWidth-1:0]    loadData;
   logic                    rangeErr;
   logic                    memWbValid, memWbRegWrite, memWbMemRead;
   logic                    memWbIsHalt, memWbIllegal, memWbRangeErr;
   logic [regAddrWidth-1:0] memWbRd;
   logic [dataWidth-1:0]    memWbAluResult, memWbLoadData;

   // Halt or fault at MEM/WB stops everything younger
   assign fault   = memWbIllegal || memWbRangeErr;
   assign haltNow = memWbValid && (memWbIsHalt || fault);
   assign kill    = halted || haltNow;

   assign instrAddr = pc;

   fetch i_fetch (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .halted     (halted),
      .pc         (pc)
   );

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ifIdValid <= 1'b0;
      end else if (redirect || kill) begin
         ifIdValid <= 1'b0;
      end else if (!stall) begin
         ifIdValid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ifIdInstr     <= instr;
         ifIdPcPlusOne <= pc + 1'b1;
      end
   end

   decode i_decode (
      .clk      (clk),
      .rstN     (rstN),
      .instr    (ifIdInstr),
      .wbEn     (wbEn),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .rs       (dRs),
      .rt       (dRt),
      .rd       (dRd),
      .opValA   (dOpA),
      .opValB   (dOpB),
      .imm      (dImm),
      .aluOp    (dAluOp),
      .useImm   (dUseImm),
      .regWrite (dRegWrite),
      .memRead  (dMemRead),
      .memWrite (dMemWrite),
      .isBranch (dIsBranch),
      .isJump   (dIsJump),
      .isHalt   (dIsHalt),
      .illegal  (dIllegal)
   );

   hazardUnit i_hazardUnit (
      .idRs        (dRs),
      .idRt        (dRt),
      .idMemRead   (idExValid && idExMemRead),
      .idRd        (idExRd),
      .exRs        (idExRs),
      .exRt        (idExRt),
      .memRd       (exMemRd),
      .memRegWrite (exMemValid && exMemRegWrite),
      .wbRd        (memWbRd),
      .wbRegWrite  (wbEn),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .loadStall   (stall)
   );

   // Stall and flush both leave a bubble in ID/EX
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idExValid <= 1'b0;
      end else begin
         idExValid <= ifIdValid && !stall && !redirect && !kill;
      end
   end

   always_ff @(posedge clk) begin
      idExRs        <= dRs;
      idExRt        <= dRt;
      idExRd        <= dRd;
      idExOpA       <= dOpA;
      idExOpB       <= dOpB;
      idExImm       <= dImm;
      idExPcPlusOne <= ifIdPcPlusOne;
      idExAluOp     <= dAluOp;
      idExUseImm    <= dUseImm;
      idExRegWrite  <= dRegWrite;
      idExMemRead   <= dMemRead;
      idExMemWrite  <= dMemWrite;
      idExIsBranch  <= dIsBranch;
      idExIsJump    <= dIsJump;
      idExIsHalt    <= dIsHalt;
      idExIllegal   <= dIllegal;
   end

   execute i_execute (
      .fwdA       (fwdA),
      .fwdB       (fwdB),
      .opValA     (idExOpA),
      .opValB     (idExOpB),
      .memResult  (exMemAluResult),
      .wbResult   (wbData),
      .imm        (idExImm),
      .aluOp      (idExAluOp),
      .useImm     (idExUseImm),
      .isBranch   (idExValid && idExIsBranch),
      .isJump     (idExValid && idExIsJump),
      .pcPlusOne  (idExPcPlusOne),
      .aluResult  (aluResult),
      .storeData  (storeData),
      .redirect   (redirect),
      .redirectPc (redirectPc)
   );

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMemValid <= 1'b0;
         memWbValid <= 1'b0;
      end else begin
         exMemValid <= idExValid && !kill;
         memWbValid <= exMemValid && !kill;
      end
   end

   always_ff @(posedge clk) begin
      exMemRd        <= idExRd;
      exMemAluResult <= aluResult;
      exMemStoreData <= storeData;
      exMemRegWrite  <= idExRegWrite;
      exMemMemRead   <= idExMemRead;
      exMemMemWrite  <= idExMemWrite;
      exMemIsHalt    <= idExIsHalt;
      exMemIllegal   <= idExIllegal;
   end

   // A younger store must not land while HALT retires
   dataMemory i_dataMemory (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (exMemAluResult),
      .wrData   (exMemStoreData),
      .memRead  (exMemValid && exMemMemRead),
      .memWrite (exMemValid && exMemMemWrite && !haltNow),
      .rdData   (loadData),
      .rangeErr (rangeErr)
   );

   always_ff @(posedge clk) begin
      memWbRd        <= exMemRd;
      memWbAluResult <= exMemAluResult;
      memWbLoadData  <= loadData;
      memWbRegWrite  <= exMemRegWrite;
      memWbMemRead   <= exMemMemRead;
      memWbIsHalt    <= exMemIsHalt;
      memWbIllegal   <= exMemIllegal;
      memWbRangeErr  <= rangeErr;
   end

   // Writeback
   assign wbEn   = memWbValid && memWbRegWrite && !fault;
   assign wbReg  = memWbRd;
   assign wbData = memWbMemRead ? memWbLoadData : memWbAluResult;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (haltNow) begin
         halted <= 1'b1;
         err    <= fault;
      end
   end

   // Everything behind the halt has been killed
   assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbEn);

endmodule

// ==== testbench/procTb.sv ====
// ################################################
// Testbench for the proc core: instruction ROM, ISA
// reference model and write trace comparison over
// directed and random programs
// ################################################
`timescale 1ns/1ps

module procTb;
   import cpuPkg::*;

   localparam int          romDepth    = 256;
   localparam int          haltTimeout = 2000;
   localparam logic [15:0] nopWord     = {opNop, 12'h000};

   logic        clk;
   logic        rstN;
   logic [15:0] instrAddr;
   logic [15:0] instr;
   logic        wbEn;
   logic [2:0]  wbReg;
   logic [15:0] wbData;
   logic        halted;
   logic        err;

   logic [15:0] rom [romDepth];
   int          loadPtr;
   logic [2:0]  expReg [$];
   logic [15:0] expData [$];
   logic        expErr;
   int          expCount;
   int          writesSeen;
   int          errors;
   int          programs;
   logic        aborted;

   proc i_proc (
      .clk       (clk),
      .rstN      (rstN),
      .instrAddr (instrAddr),
      .instr     (instr),
      .wbEn      (wbEn),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted),
      .err       (err)
   );

   // Combinational ROM that reads NOP past its end
   assign instr = (instrAddr < romDepth) ? rom[instrAddr[7:0]] : nopWord;

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [15:0] encR(opcodeT op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic logic [15:0] encI(opcodeT op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [15:0] encJ(int off);
      return {opJ, off[11:0]};
   endfunction

   function automatic void clearRom();
      for (int i = 0; i < romDepth; i++) begin
         rom[i] = nopWord;
      end
      loadPtr = 0;
   endfunction

   function automatic void put(logic [15:0] word);
      rom[loadPtr] = word;
      loadPtr++;
   endfunction

   // Architectural model of the ROM program that fills the expected write trace
   function automatic void interpret();
      logic [15:0] regs [8];
      logic [15:0] dmem [dmemDepth];
      logic [15:0] pc;
      logic [15:0] ins;
      logic [15:0] imm;
      logic [15:0] sum;
      logic [15:0] val;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic        wr;
      logic        done;
      int          steps;
      expReg.delete();
      expData.delete();
      expErr   = 1'b0;
      expCount = 0;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < dmemDepth; i++) begin
         dmem[i] = '0;
      end
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 5000) begin
         ins   = (pc < romDepth) ? rom[pc[7:0]] : nopWord;
         rd    = ins[11:9];
         rs    = ins[8:6];
         rt    = ins[5:3];
         imm   = {{10{ins[5]}}, ins[5:0]};
         sum   = regs[rs] + imm;
         pc    = pc + 16'd1;
         wr    = 1'b0;
         val   = '0;
         steps++;
         case (ins[15:12])
            opAdd: begin
               val = regs[rs] + regs[rt];
               wr  = 1'b1;
            end
            opSub: begin
               val = regs[rs] - regs[rt];
               wr  = 1'b1;
            end
            opAnd: begin
               val = regs[rs] & regs[rt];
               wr  = 1'b1;
            end
            opXor: begin
               val = regs[rs] ^ regs[rt];
               wr  = 1'b1;
            end
            opAddi: begin
               val = sum;
               wr  = 1'b1;
            end
            opLd: begin
               if (sum >= dmemDepth) begin
                  expErr = 1'b1;
                  done   = 1'b1;
               end else begin
                  val = dmem[sum[7:0]];
                  wr  = 1'b1;
               end
            end
            opSt: begin
               if (sum >= dmemDepth) begin
                  expErr = 1'b1;
                  done   = 1'b1;
               end else begin
                  dmem[sum[7:0]] = regs[rd];
               end
            end
            opBeqz: begin
               if (regs[rs] == '0) begin
                  pc = pc + imm;
               end
            end
            opJ:    pc = pc + {{4{ins[11]}}, ins[11:0]};
            opHalt: done = 1'b1;
            opNop:  ;
            default: begin
               expErr = 1'b1;
               done   = 1'b1;
            end
         endcase
         // A write to r0 still shows on the trace
         if (wr) begin
            expReg.push_back(rd);
            expData.push_back(val);
            expCount++;
            if (rd != 3'd0) begin
               regs[rd] = val;
            end
         end
      end
   endfunction

   always @(posedge clk) begin
      if (rstN && wbEn) begin
         writesSeen++;
         assert (expReg.size() > 0) else begin
            errors++;
            $display("[ERROR] %0t: unexpected write r%0d = %h", $time, wbReg, wbData);
         end
         if (expReg.size() > 0) begin
            assert (wbReg == expReg[0] && wbData == expData[0]) else begin
               errors++;
               $display("[ERROR] %0t: write r%0d = %h, expected r%0d = %h",
                        $time, wbReg, wbData, expReg[0], expData[0]);
            end
            void'(expReg.pop_front());
            void'(expData.pop_front());
         end
      end
   end

   task automatic runProgram(input string name);
      int n;
      if (aborted) begin
         return;
      end
      programs++;
      interpret();
      writesSeen = 0;
      rstN = 1'b0;
      repeat (3) @(negedge clk);
      assert (!wbEn && !halted && !err && instrAddr == '0) else begin
         errors++;
         $display("[ERROR] %0t: %s outputs not cleared by reset", $time, name);
      end
      rstN = 1'b1;
      n = 0;
      while (!halted && n < haltTimeout) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         errors++;
         aborted = 1'b1;
         $display("Program %s did not halt within %0d cycles", name, haltTimeout);
      end else begin
         // Watch a few cycles for any stray write
         n = 0;
         while (n < 4) begin
            @(negedge clk);
            n++;
         end
         assert (err == expErr) else begin
            errors++;
            $display("[ERROR] %0t: %s err = %0b, expected %0b", $time, name, err, expErr);
         end
         assert (writesSeen == expCount && expReg.size() == 0) else begin
            errors++;
            $display("[ERROR] %0t: %s saw %0d writes, expected %0d",
                     $time, name, writesSeen, expCount);
         end
      end
   endtask

   // Straight-line ALU, ADDI, LD and ST with loads only from stored words
   task automatic buildRandomProgram();
      int storedQ [$];
      int len;
      int kind;
      int off;
      clearRom();
      len = 10 + int'($urandom % 15);
      for (int i = 0; i < len; i++) begin
         kind = int'($urandom % 8);
         if (kind >= 6 && storedQ.size() == 0) begin
            kind = 5;
         end
         if (kind < 4) begin
            put(encR(opcodeT'(kind), $urandom % 8, $urandom % 8, $urandom % 8));
         end else if (kind == 4) begin
            put(encI(opAddi, $urandom % 8, $urandom % 8, $urandom % 64));
         end else if (kind == 5) begin
            off = int'($urandom % 32);
            storedQ.push_back(off);
            put(encI(opSt, $urandom % 8, 0, off));
         end else begin
            off = storedQ[$urandom % storedQ.size()];
            put(encI(opLd, $urandom % 8, 0, off));
         end
      end
      put(encR(opHalt, 0, 0, 0));
   endtask

   initial begin
      rstN     = 1'b0;
      errors   = 0;
      programs = 0;
      aborted  = 1'b0;
      void'($urandom(19));
      clearRom();
      @(negedge clk);

      // Forwarding from both stages and a write after HALT
      clearRom();
      put(encI(opAddi, 1, 0, 5));
      put(encI(opAddi, 2, 0, -3));
      put(encR(opAdd, 3, 1, 2));
      put(encR(opSub, 4, 3, 1));
      put(encR(opAnd, 5, 4, 3));
      put(encR(opXor, 6, 5, 4));
      put(encR(opAdd, 0, 6, 6));
      put(encR(opAdd, 7, 0, 6));
      put(encR(opHalt, 0, 0, 0));
      put(encI(opAddi, 2, 0, 9));
      runProgram("alu chain");

      // Stores read back from the same words, with load-use on ALU operands
      clearRom();
      put(encI(opAddi, 1, 0, 10));
      put(encI(opAddi, 2, 0, -7));
      put(encI(opSt, 2, 1, 4));
      put(encI(opLd, 3, 0, 14));
      put(encR(opAdd, 4, 3, 3));
      put(encI(opSt, 4, 0, 3));
      put(encI(opLd, 5, 0, 3));
      put(encI(opLd, 6, 1, 4));
      put(encR(opSub, 7, 5, 6));
      put(encR(opHalt, 0, 0, 0));
      runProgram("store and load");

      // Taken and untaken BEQZ, backward and forward J
      clearRom();
      put(encI(opAddi, 1, 0, 2));
      put(encI(opBeqz, 0, 0, 2));
      put(encI(opAddi, 2, 0, 11));
      put(encI(opAddi, 3, 0, 12));
      put(encI(opAddi, 1, 1, -1));
      put(encI(opBeqz, 0, 1, 1));
      put(encJ(-3));
      put(encJ(2));
      put(encI(opAddi, 5, 0, 1));
      put(encI(opAddi, 6, 0, 1));
      put(encR(opHalt, 0, 0, 0));
      runProgram("branches");

      clearRom();
      put(encI(opAddi, 1, 0, 7));
      put(encR(opAdd, 2, 1, 1));
      put(16'hF000);
      put(encI(opAddi, 3, 0, 1));
      put(encR(opHalt, 0, 0, 0));
      runProgram("illegal opcode");

      // Base reaches 248 and offset 8 lands on 256
      clearRom();
      put(encI(opAddi, 1, 0, 31));
      put(encR(opAdd, 1, 1, 1));
      put(encR(opAdd, 1, 1, 1));
      put(encR(opAdd, 1, 1, 1));
      put(encI(opLd, 2, 1, 8));
      put(encI(opAddi, 3, 0, 1));
      put(encR(opHalt, 0, 0, 0));
      runProgram("load out of range");

      for (int i = 0; i < 20; i++) begin
         buildRandomProgram();
         runProgram($sformatf("random %0d", i));
      end

      $display("Checks done: %0d programs, %0d errors", programs, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
logic/cpuPkg.sv
logic/fetch.sv
logic/regFile.sv
logic/decode.sv
logic/hazardUnit.sv
logic/execute.sv
logic/dataMemory.sv
logic/proc.sv
testbench/procTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = procTb
FILELIST = tb.f
PASS     = Test OK

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
